//--- rtl/rv32i_pkg.sv
package rv32i_pkg;

    // RV32I major opcodes seen by the back end
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,  // Load upper immediate
        op_auipc = 7'b0010111,  // Add upper immediate to pc
        op_jal   = 7'b1101111,  // Jump and link
        op_jalr  = 7'b1100111,  // Jump and link register
        op_br    = 7'b1100011,  // Conditional branch
        op_load  = 7'b0000011,  // Loads
        op_store = 7'b0100011,  // Stores
        op_imm   = 7'b0010011,  // Register-immediate ALU ops
        op_reg   = 7'b0110011   // Register-register ALU ops
    } opcode_t;

    typedef enum logic [2:0] {
        lb  = 3'b000,           // Signed byte
        lh  = 3'b001,           // Signed halfword
        lw  = 3'b010,           // Full word
        lbu = 3'b100,           // Unsigned byte
        lhu = 3'b101            // Unsigned halfword
    } load_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000,            // Byte store
        sh = 3'b001,            // Halfword store
        sw = 3'b010             // Word store
    } store_funct3_t;

    // Source of the register write value
    typedef enum logic [1:0] {
        alu   = 2'b00,          // ALU result
        u_imm = 2'b01,          // U-type immediate
        cmp   = 2'b10,          // Comparison bit
        mdr   = 2'b11           // Extended load data
    } wb_sel_t;

    typedef struct packed {
        logic          mem_read;
        logic          mem_write;
        load_funct3_t  load_funct3;
        store_funct3_t store_funct3;
    } mem_ctrl_t;

    typedef struct packed {
        opcode_t    opcode;
        mem_ctrl_t  mem_ctrl;
        wb_sel_t    wb_sel;
        logic       reg_write;
        logic [4:0] rd;
    } ctrl_word_t;

    typedef struct packed {
        ctrl_word_t  ctrl;
        logic [31:0] alu_out;
        logic [31:0] mar;           // Effective byte address
        logic [31:0] mem_data_out;  // Store value before lane shift
        logic [31:0] u_imm;
        logic        cmp_out;
    } ex_mem_stage_t;

    typedef struct packed {
        ctrl_word_t  ctrl;
        logic [31:0] alu_out;
        logic [31:0] u_imm;
        logic        cmp_out;
        logic [31:0] mdr;           // Raw word from the bus
        logic [1:0]  byte_offset;
        logic        misaligned;
    } mem_wb_stage_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] rd_data;
        logic        reg_write;
        logic        trap;
    } wb_result_t;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [29:0] adr;           // Word address
        logic [31:0] dat;
    } wb_m2s_t;

    // Wishbone classic, slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_s2m_t;

endpackage

//--- rtl/mem_stage.sv
`timescale 1ns/100ps

module mem_stage
    import rv32i_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          in_valid,
    input  ex_mem_stage_t ex_mem,
    output logic          in_ready,
    output wb_m2s_t       bus_m2s,
    input  wb_s2m_t       bus_s2m,
    output mem_wb_stage_t mem_out,
    output logic          mem_valid
);

    typedef enum logic {
        st_idle,                    // Ready for a new operation
        st_bus                      // Wishbone cycle open
    } state_t;

    state_t      state;
    mem_ctrl_t   mc;
    logic [1:0]  offset;
    logic        accept;
    logic        is_mem;
    logic        misaligned;
    logic        start_bus;
    logic [31:0] st_data;
    logic [3:0]  st_sel;

    logic        bus_act;           // Drives cyc and stb together
    logic        bus_we;
    logic [3:0]  bus_sel;
    logic [29:0] bus_adr;
    logic [31:0] bus_dat;

    ctrl_word_t  ctrl_q;
    logic [31:0] alu_q;
    logic [31:0] uimm_q;
    logic        cmp_q;
    logic [31:0] mdr_q;             // Memory data register
    logic [1:0]  off_q;
    logic        mis_q;

    assign mc        = ex_mem.ctrl.mem_ctrl;
    assign offset    = ex_mem.mar[1:0];
    assign in_ready  = (state == st_idle);  // Low while the bus is busy
    assign accept    = in_valid & in_ready;
    assign is_mem    = mc.mem_read | mc.mem_write;
    assign start_bus = is_mem & ~misaligned; // Misaligned ops never reach the bus

    // Natural alignment check for halfword and word accesses
    always_comb begin
        misaligned = 1'b0;
        if (mc.mem_read) begin
            case (mc.load_funct3)
                lh, lhu: misaligned = offset[0];
                lw:      misaligned = |offset;
                default: misaligned = 1'b0;     // Bytes always aligned
            endcase
        end else if (mc.mem_write) begin
            case (mc.store_funct3)
                sh:      misaligned = offset[0];
                sw:      misaligned = |offset;
                default: misaligned = 1'b0;
            endcase
        end
    end

    // Lane shift and byte selects
    always_comb begin
        st_data = ex_mem.mem_data_out;
        st_sel  = 4'b1111;                      // Reads fetch the whole word
        if (mc.mem_write) begin
            case (mc.store_funct3)
                sb: begin
                    st_data = ex_mem.mem_data_out << {offset, 3'b000};
                    st_sel  = 4'b0001 << offset;
                end
                sh: begin
                    st_data = ex_mem.mem_data_out << {offset[1], 4'b0000};
                    st_sel  = 4'b0011 << {offset[1], 1'b0};  // Lanes 0-1 or 2-3
                end
                default: begin
                    st_data = ex_mem.mem_data_out;
                    st_sel  = 4'b1111;
                end
            endcase
        end
    end

    // Idle/bus FSM and memory data register
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            bus_act   <= 1'b0;
            mem_valid <= 1'b0;
            mdr_q     <= '0;
        end else begin
            mem_valid <= 1'b0;                  // One-cycle pulse
            case (state)
                st_idle: begin
                    if (accept && start_bus) begin
                        state   <= st_bus;
                        bus_act <= 1'b1;        // Open cycle at E0
                    end else if (accept) begin
                        mem_valid <= 1'b1;      // No bus, done next cycle
                    end
                end
                st_bus: begin
                    if (bus_s2m.ack) begin
                        state     <= st_idle;
                        bus_act   <= 1'b0;      // Drop cyc and stb on ack
                        mem_valid <= 1'b1;
                        if (!bus_we) begin
                            mdr_q <= bus_s2m.dat;   // Capture read word
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Request and record payload, held until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            bus_we  <= mc.mem_write;
            bus_sel <= st_sel;
            bus_adr <= ex_mem.mar[31:2];
            bus_dat <= st_data;
            ctrl_q  <= ex_mem.ctrl;
            alu_q   <= ex_mem.alu_out;
            uimm_q  <= ex_mem.u_imm;
            cmp_q   <= ex_mem.cmp_out;
            off_q   <= offset;
            mis_q   <= misaligned;
        end
    end

    always_comb begin
        bus_m2s.cyc = bus_act;
        bus_m2s.stb = bus_act;
        bus_m2s.we  = bus_we;
        bus_m2s.sel = bus_sel;
        bus_m2s.adr = bus_adr;
        bus_m2s.dat = bus_dat;
    end

    always_comb begin
        mem_out.ctrl        = ctrl_q;
        mem_out.alu_out     = alu_q;
        mem_out.u_imm       = uimm_q;
        mem_out.cmp_out     = cmp_q;
        mem_out.mdr         = mdr_q;
        mem_out.byte_offset = off_q;
        mem_out.misaligned  = mis_q;
    end

endmodule

//--- rtl/wb_stage.sv
`timescale 1ns/100ps

module wb_stage
    import rv32i_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  mem_wb_stage_t mem_out,
    input  logic          mem_valid,
    output wb_result_t    result,
    output logic          result_valid
);

    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    logic [31:0] ld_val;
    logic [31:0] wr_data;
    logic        is_store;
    logic        do_write;

    // Byte and halfword pick from the MDR
    always_comb begin
        case (mem_out.byte_offset)
            2'b00:   ld_byte = mem_out.mdr[7:0];
            2'b01:   ld_byte = mem_out.mdr[15:8];
            2'b10:   ld_byte = mem_out.mdr[23:16];
            default: ld_byte = mem_out.mdr[31:24];
        endcase
        ld_half = mem_out.byte_offset[1] ? mem_out.mdr[31:16] : mem_out.mdr[15:0];
    end

    // Sign or zero extension by load type
    always_comb begin
        case (mem_out.ctrl.mem_ctrl.load_funct3)
            lb:      ld_val = {{24{ld_byte[7]}}, ld_byte};
            lbu:     ld_val = {24'b0, ld_byte};
            lh:      ld_val = {{16{ld_half[15]}}, ld_half};
            lhu:     ld_val = {16'b0, ld_half};
            default: ld_val = mem_out.mdr;      // LW
        endcase
    end

    // Write value mux
    always_comb begin
        case (mem_out.ctrl.wb_sel)
            alu:     wr_data = mem_out.alu_out;
            u_imm:   wr_data = mem_out.u_imm;
            cmp:     wr_data = {31'b0, mem_out.cmp_out};
            default: wr_data = ld_val;
        endcase
    end

    assign is_store = (mem_out.ctrl.opcode == op_store);
    assign do_write = mem_out.ctrl.reg_write & ~is_store & ~mem_out.misaligned
                    & (mem_out.ctrl.rd != 5'd0);    // x0 stays zero

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid) begin
            result.rd        <= mem_out.ctrl.rd;
            result.rd_data   <= wr_data;
            result.reg_write <= do_write;
            result.trap      <= mem_out.misaligned;  // Misaligned access trap
        end
    end

endmodule

//--- rtl/data_ram.sv
`timescale 1ns/100ps

module data_ram
    import rv32i_pkg::*;
#(
    parameter int RAM_WORDS = 256
)
(
    input  logic    clk,
    input  logic    rst,
    input  wb_m2s_t bus_m2s,
    output wb_s2m_t bus_s2m
);

    localparam int AW = $clog2(RAM_WORDS);  // Index width

    logic [31:0]   mem [RAM_WORDS];
    logic [AW-1:0] idx;
    logic          req;
    logic          ack_q;
    logic [31:0]   rd_q;

    assign idx = bus_m2s.adr[AW-1:0];       // Upper address bits ignored
    // New request only while ack is low, keeps ack to one cycle
    assign req = bus_m2s.cyc & bus_m2s.stb & ~ack_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    // Byte-lane write and registered read word
    always_ff @(posedge clk) begin
        if (req) begin
            if (bus_m2s.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (bus_m2s.sel[i]) begin
                        mem[idx][8*i +: 8] <= bus_m2s.dat[8*i +: 8];
                    end
                end
            end else begin
                rd_q <= mem[idx];           // Valid together with ack
            end
        end
    end

    always_comb begin
        bus_s2m.ack = ack_q;
        bus_s2m.dat = rd_q;
    end

endmodule

//--- rtl/mem_wb_top.sv
`timescale 1ns/100ps

module mem_wb_top
    import rv32i_pkg::*;
#(
    parameter int RAM_WORDS = 256
)
(
    input  logic          clk,
    input  logic          rst,
    input  logic          in_valid,
    input  ex_mem_stage_t ex_mem,
    output logic          in_ready,
    output wb_result_t    result,
    output logic          result_valid
);

    wb_m2s_t       bus_m2s;     // Memory stage to RAM
    wb_s2m_t       bus_s2m;     // RAM to memory stage
    mem_wb_stage_t mem_out;
    logic          mem_valid;

    mem_stage u_mem (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .ex_mem    (ex_mem),
        .in_ready  (in_ready),
        .bus_m2s   (bus_m2s),
        .bus_s2m   (bus_s2m),
        .mem_out   (mem_out),
        .mem_valid (mem_valid)
    );

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_ram (
        .clk     (clk),
        .rst     (rst),
        .bus_m2s (bus_m2s),
        .bus_s2m (bus_s2m)
    );

    wb_stage u_wb (
        .clk          (clk),
        .rst          (rst),
        .mem_out      (mem_out),
        .mem_valid    (mem_valid),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

//--- verif/tb_mem_wb.sv
`timescale 1ns/100ps

module tb_mem_wb
    import rv32i_pkg::*;
;

    localparam int RAM_WORDS  = 64;
    localparam int LAT_NO_BUS = 2;       // Accept edge counted as cycle 1
    localparam int LAT_BUS    = 4;       // Two extra edges for the bus cycle

    logic          clk;
    logic          rst;
    logic          in_valid;
    ex_mem_stage_t ex_mem;
    logic          in_ready;
    wb_result_t    result;
    logic          result_valid;

    string         names[$];             // Table of rows
    ex_mem_stage_t stim[$];
    wb_result_t    expect_res[$];
    int            expect_lat[$];

    logic [7:0]    ref_mem [RAM_WORDS*4]; // Byte model of the RAM
    logic [31:0]   last_mdr;              // Model of the memory data register
    int            cycle_cnt;
    int            limit;

    mem_wb_top #(
        .RAM_WORDS (RAM_WORDS)
    ) UUT (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .ex_mem       (ex_mem),
        .in_ready     (in_ready),
        .result       (result),
        .result_valid (result_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;          // 40 ns period
    end

    // Watchdog on total run length
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > limit) begin
            $display("Timeout: the run hung after %0d cycles without finishing", cycle_cnt);
            $display("ERRORS FOUND");
            $fatal(1, "Run stopped by watchdog");
        end
    end

    function automatic logic [31:0] word_at(logic [31:0] addr);
        int a;
        a = {addr[31:2], 2'b00};
        return {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
    endfunction

    // Pick and extend a load value from a whole word
    function automatic logic [31:0] extend_load(logic [31:0] w, logic [2:0] f3, logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*off +: 8];
        h = off[1] ? w[31:16] : w[15:0];
        case (f3)
            3'b000:  return {{24{b[7]}}, b};   // LB
            3'b100:  return {24'b0, b};        // LBU
            3'b001:  return {{16{h[15]}}, h};  // LH
            3'b101:  return {16'b0, h};        // LHU
            default: return w;                 // LW
        endcase
    endfunction

    task automatic add_mem_row(string name, logic is_st, logic [2:0] f3, logic [31:0] addr,
                               logic [4:0] rd, logic [31:0] data);
        ex_mem_stage_t op;
        wb_result_t    exp;
        logic          mis;
        op                              = '0;
        op.ctrl.opcode                  = is_st ? op_store : op_load;
        op.ctrl.mem_ctrl.mem_read       = ~is_st;
        op.ctrl.mem_ctrl.mem_write      = is_st;
        op.ctrl.mem_ctrl.load_funct3    = load_funct3_t'(f3);
        op.ctrl.mem_ctrl.store_funct3   = store_funct3_t'(f3);
        op.ctrl.wb_sel                  = is_st ? alu : mdr;
        op.ctrl.reg_write               = 1'b1;  // Stores must still write nothing
        op.ctrl.rd                      = rd;
        op.alu_out                      = addr;
        op.mar                          = addr;
        op.mem_data_out                 = data;
        mis = (f3[1:0] == 2'b01) ? addr[0] : (f3[1:0] == 2'b10) ? |addr[1:0] : 1'b0;
        if (!mis && is_st) begin
            for (int i = 0; i < (1 << f3[1:0]); i++) begin
                ref_mem[addr + i] = data[8*i +: 8];  // Low bytes land at the address
            end
        end else if (!mis) begin
            last_mdr = word_at(addr);
        end
        exp.rd        = rd;
        exp.rd_data   = is_st ? addr : extend_load(last_mdr, f3, addr[1:0]);
        exp.reg_write = ~is_st & ~mis & (rd != 5'd0);
        exp.trap      = mis;
        names.push_back(name);
        stim.push_back(op);
        expect_res.push_back(exp);
        expect_lat.push_back(mis ? LAT_NO_BUS : LAT_BUS);
    endtask

    task automatic add_alu_row(string name, opcode_t opc, wb_sel_t sel, logic [4:0] rd);
        ex_mem_stage_t op;
        wb_result_t    exp;
        op                = '0;
        op.ctrl.opcode    = opc;
        op.ctrl.wb_sel    = sel;
        op.ctrl.reg_write = 1'b1;
        op.ctrl.rd        = rd;
        op.alu_out        = $urandom;
        op.u_imm          = $urandom & 32'hffff_f000;
        op.cmp_out        = $urandom;
        case (sel)
            alu:     exp.rd_data = op.alu_out;
            u_imm:   exp.rd_data = op.u_imm;
            default: exp.rd_data = {31'b0, op.cmp_out};
        endcase
        exp.rd        = rd;
        exp.reg_write = (rd != 5'd0);
        exp.trap      = 1'b0;
        names.push_back(name);
        stim.push_back(op);
        expect_res.push_back(exp);
        expect_lat.push_back(LAT_NO_BUS);
    endtask

    task automatic check_result(string name, wb_result_t exp, wb_result_t act);
        string exp_s;
        string act_s;
        if (act !== exp) begin
            exp_s = $sformatf("rd=%0d data=%h we=%b trap=%b",
                              exp.rd, exp.rd_data, exp.reg_write, exp.trap);
            act_s = $sformatf("rd=%0d data=%h we=%b trap=%b",
                              act.rd, act.rd_data, act.reg_write, act.trap);
            $display("** Error %s: expected %s, actual %s", name, exp_s, act_s);
            $display("ERRORS FOUND");
            $fatal(1, "Result mismatch");
        end
    endtask

    task automatic check_latency(string name, int exp, int act);
        if (act != exp) begin
            $display("** Error %s: expected latency %0d, actual latency %0d", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "Latency mismatch");
        end
    endtask

    task automatic check_ready(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("** Error %s: expected in_ready %b, actual in_ready %b", name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "Ready mismatch");
        end
    endtask

    // Offer one row, wait for accept, then count cycles to the result
    task automatic run_row(int i);
        int   cycles;
        logic bus_op;
        bus_op   = (expect_lat[i] == LAT_BUS);
        ex_mem   = stim[i];
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);                  // Accepting edge
        #2;
        in_valid = 1'b0;
        ex_mem   = '0;
        cycles   = 1;
        forever begin
            @(negedge clk);
            // Busy from the accept edge until the ack edge
            check_ready(names[i], !(bus_op && cycles <= 2), in_ready);
            if (result_valid) break;
            @(posedge clk);
            cycles++;
        end
        check_result(names[i], expect_res[i], result);
        check_latency(names[i], expect_lat[i], cycles);
        @(posedge clk);
        #2;
    endtask

    initial begin
        rst       = 1'b1;
        in_valid  = 1'b0;
        ex_mem    = '0;
        cycle_cnt = 0;
        limit     = 1000;
        last_mdr  = '0;                  // MDR is cleared by reset
        void'($urandom(32'hd54e_8c97));

        add_mem_row("sw_word", 1, 3'b010, 32'h40, 5'd1, $urandom);
        add_mem_row("lw_word", 0, 3'b010, 32'h40, 5'd5, 32'h0);
        add_mem_row("sw_fill_b", 1, 3'b010, 32'h50, 5'd1, $urandom);
        for (int k = 0; k < 4; k++) begin
            add_mem_row($sformatf("sb_off%0d", k), 1, 3'b000, 32'h50 + k, 5'd2, $urandom);
            add_mem_row($sformatf("lw_after_sb%0d", k), 0, 3'b010, 32'h50, 5'd6, 32'h0);
            add_mem_row($sformatf("lb_off%0d", k), 0, 3'b000, 32'h50 + k, 5'd7, 32'h0);
            add_mem_row($sformatf("lbu_off%0d", k), 0, 3'b100, 32'h50 + k, 5'd8, 32'h0);
        end
        add_mem_row("sw_fill_h", 1, 3'b010, 32'h60, 5'd1, $urandom);
        for (int k = 0; k < 4; k += 2) begin
            add_mem_row($sformatf("sh_off%0d", k), 1, 3'b001, 32'h60 + k, 5'd3, $urandom);
            add_mem_row($sformatf("lw_after_sh%0d", k), 0, 3'b010, 32'h60, 5'd6, 32'h0);
            add_mem_row($sformatf("lh_off%0d", k), 0, 3'b001, 32'h60 + k, 5'd7, 32'h0);
            add_mem_row($sformatf("lhu_off%0d", k), 0, 3'b101, 32'h60 + k, 5'd8, 32'h0);
        end
        add_alu_row("lui", op_lui, u_imm, 5'd9);
        add_alu_row("addi", op_imm, alu, 5'd10);
        add_alu_row("slt", op_reg, cmp, 5'd11);
        add_mem_row("sh_odd", 1, 3'b001, 32'h61, 5'd4, $urandom);
        add_mem_row("lh_odd", 0, 3'b001, 32'h63, 5'd12, 32'h0);
        add_mem_row("sw_off2", 1, 3'b010, 32'h62, 5'd4, $urandom);
        add_mem_row("lw_off1", 0, 3'b010, 32'h41, 5'd13, 32'h0);
        add_mem_row("lw_unchanged", 0, 3'b010, 32'h60, 5'd14, 32'h0);
        add_alu_row("addi_x0", op_imm, alu, 5'd0);
        add_mem_row("lw_x0", 0, 3'b010, 32'h40, 5'd0, 32'h0);
        limit = stim.size() * 6 + 40;    // Worst row plus reset margin

        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i < stim.size(); i++) begin
            run_row(i);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- flist.f
rtl/rv32i_pkg.sv
rtl/mem_stage.sv
rtl/wb_stage.sv
rtl/data_ram.sv
rtl/mem_wb_top.sv
verif/tb_mem_wb.sv

//--- Bender.yml
package:
  name: mem_wb

sources:
  - rtl/rv32i_pkg.sv
  - rtl/mem_stage.sv
  - rtl/wb_stage.sv
  - rtl/data_ram.sv
  - rtl/mem_wb_top.sv
  - target: test
    files:
      - verif/tb_mem_wb.sv
